// ==== verilog/capture_pkg.sv ====
package capture_pkg;

  // one i/q sample, 16 bit i in the upper half and 16 bit q in the lower half
  localparam int sample_w = 32;

  typedef logic [sample_w-1:0] sample_t;     // sample or counter value

  // two lanes side by side, upper lane in bits 63:32
  typedef logic [2*sample_w-1:0] fifo_word_t;

  // dds pipeline countdown, wide enough for latencies up to 15
  typedef logic [3:0] latency_cnt_t;

endpackage

// ==== verilog/route_pkg.sv ====
package route_pkg;

  // one nibble of the route word per lane
  localparam int lane_sel_w = 4;
  localparam int route_w    = 2 * lane_sel_w;

  // nibble positions in the route word
  localparam int lower_lsb = 0;           // lower lane
  localparam int upper_lsb = lane_sel_w;  // upper lane

  // lane source codes, anything above 3 behaves like src_adc
  typedef enum logic [lane_sel_w-1:0] {
    src_adc        = 4'd0,  // adc i/q sample
    src_dac        = 4'd1,  // dac/dds i/q sample
    src_adc_count  = 4'd2,  // capture sample counter
    src_glbl_count = 4'd3   // free running cycle counter
  } lane_src_e;

endpackage

// ==== verilog/capture_ctrl.sv ====
`timescale 1ns/1ps

module capture_ctrl #(
  parameter int dds_latency = 2  // chirp pipeline delay in clocks, 1 to 15
) (
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  logic adc_enable,    // capture request from software
  input  logic chirp_init,    // chirp start pulse, loads the countdown
  output logic capture_on,    // second enable stage that gates fifo writes
  output logic capture_last   // final write of the current capture
);

  import capture_pkg::*;

  typedef enum logic {
    st_idle,
    st_capture
  } state_e;

  state_e       state;
  logic         en_r;         // first enable stage
  latency_cnt_t latency_cnt;  // remaining dds pipeline clocks
  logic         hold;         // freeze the fsm while the chirp is in flight

  assign hold = (latency_cnt != '0);

  // second enable stage only moves once the dds pipeline has drained
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_r  <= 1'b0;
      state <= st_idle;
    end else begin
      en_r <= adc_enable;
      if (!hold) begin
        case (state)
          st_idle: begin
            if (en_r)
              state <= st_capture;  // window opens
          end
          st_capture: begin
            if (!en_r)
              state <= st_idle;     // window closes
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // countdown reload on every chirp start, then runs down to zero and sticks
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset)
      latency_cnt <= '0;
    else if (chirp_init)
      latency_cnt <= latency_cnt_t'(dds_latency - 1);
    else if (hold)
      latency_cnt <= latency_cnt - 1'b1;
  end

  assign capture_on   = (state == st_capture);
  assign capture_last = capture_on & ~en_r;  // enable already dropped at stage one

  // countdown stays inside the loaded range
  a_cnt_bound: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    latency_cnt <= latency_cnt_t'(dds_latency - 1));

endmodule

// ==== verilog/sample_counters.sv ====
`timescale 1ns/1ps

module sample_counters (
  input  logic                 clk_245_76MHz,
  input  logic                 cpu_reset,
  input  logic                 capture_on,   // capture window from capture_ctrl
  input  logic                 data_valid,   // sample strobe
  output capture_pkg::sample_t glbl_count,   // clocks since reset
  output capture_pkg::sample_t adc_count     // samples taken inside capture windows
);

  // free running, wraps at 2**32
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset)
      glbl_count <= '0;
    else
      glbl_count <= glbl_count + 1'b1;
  end

  // counts only valid samples while capturing
  // keeps counting across windows, never cleared except by reset
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset)
      adc_count <= '0;
    else if (capture_on && data_valid)
      adc_count <= adc_count + 1'b1;
  end

endmodule

// ==== verilog/lane_router.sv ====
`timescale 1ns/1ps

module lane_router (
  input  logic                         clk_245_76MHz,
  input  logic                         cpu_reset,
  input  logic [route_pkg::route_w-1:0] route_ctrl,  // one source nibble per lane
  input  logic                         data_valid,
  input  capture_pkg::sample_t         adc_data,     // adc i/q
  input  capture_pkg::sample_t         dac_data,     // dds i/q fed to the dac
  input  capture_pkg::sample_t         glbl_count,
  input  capture_pkg::sample_t         adc_count,
  output capture_pkg::sample_t         lane_upper,   // goes to fifo bits 63:32
  output capture_pkg::sample_t         lane_lower,   // goes to fifo bits 31:0
  output logic                         lane_valid    // data_valid, one clock later
);

  import capture_pkg::*;
  import route_pkg::*;

  // one nibble to one source
  function automatic sample_t pick_source(input logic [lane_sel_w-1:0] code);
    lane_src_e src;
    src = lane_src_e'(code);
    case (src)
      src_dac:        pick_source = dac_data;
      src_adc_count:  pick_source = adc_count;    // debug ramp, moves with captures
      src_glbl_count: pick_source = glbl_count;   // debug ramp, moves every clock
      default:        pick_source = adc_data;     // src_adc and unused codes
    endcase
  endfunction

  // valid travels with the lanes
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset)
      lane_valid <= 1'b0;
    else
      lane_valid <= data_valid;
  end

  // lane payload, route word may change on any clock
  always_ff @(posedge clk_245_76MHz) begin
    lane_lower <= pick_source(route_ctrl[lower_lsb +: lane_sel_w]);
    lane_upper <= pick_source(route_ctrl[upper_lsb +: lane_sel_w]);
  end

endmodule

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
  parameter int fifo_depth = 16  // entries, power of two, at least 2
) (
  input  logic                    clk_245_76MHz,
  input  logic                    cpu_reset,
  input  logic                    wr_en,      // push request
  input  capture_pkg::fifo_word_t wr_data,
  input  logic                    wr_last,    // end of capture mark for this word
  output capture_pkg::fifo_word_t tdata,      // head entry, show-ahead
  output logic                    tvalid,
  output logic                    tlast,
  input  logic                    tready,
  output logic                    overflow    // sticky, a write was dropped
);

  import capture_pkg::*;

  localparam int addr_w = $clog2(fifo_depth);

  fifo_word_t        data_mem [fifo_depth];  // payload
  logic              last_mem [fifo_depth];  // tlast per entry
  logic [addr_w:0]   wr_ptr;                 // extra msb tells full from empty
  logic [addr_w:0]   rd_ptr;
  logic [addr_w:0]   fill;                   // entries held
  logic [addr_w-1:0] wr_addr;
  logic [addr_w-1:0] rd_addr;
  logic              full;
  logic              push;
  logic              pop;

  assign wr_addr = wr_ptr[addr_w-1:0];
  assign rd_addr = rd_ptr[addr_w-1:0];
  assign fill    = wr_ptr - rd_ptr;
  assign full    = (fill == (addr_w + 1)'(fifo_depth));

  assign push = wr_en & ~full;      // full write is lost
  assign pop  = tvalid & tready;    // stream handshake

  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      data_mem[wr_addr] <= wr_data;
      last_mem[wr_addr] <= wr_last;
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && full)
        overflow <= 1'b1;  // held until reset
    end
  end

  // head of queue drives the stream directly
  assign tvalid = (fill != '0);
  assign tdata  = data_mem[rd_addr];
  assign tlast  = tvalid & last_mem[rd_addr];  // no stale mark on an empty fifo

  // write pointer never laps the read pointer
  a_ptr_order: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    fill <= (addr_w + 1)'(fifo_depth));

  // stalled word is held until taken
  a_stall_hold: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast));

endmodule

// ==== verilog/adc_capture_top.sv ====
`timescale 1ns/1ps

module adc_capture_top #(
  parameter int dds_latency = 2,   // chirp pipeline delay, 1 to 15
  parameter int fifo_depth  = 16   // capture fifo entries, power of two
) (
  input  logic                         clk_245_76MHz,
  input  logic                         cpu_reset,
  input  capture_pkg::sample_t         adc_data,     // adc i/q
  input  capture_pkg::sample_t         dac_data,     // dds i/q
  input  logic                         data_valid,   // strobe for both samples
  input  logic                         chirp_init,
  input  logic                         adc_enable,
  input  logic [route_pkg::route_w-1:0] route_ctrl,
  output capture_pkg::fifo_word_t      tdata,
  output logic                         tvalid,
  output logic                         tlast,
  input  logic                         tready,
  output logic                         overflow
);

  import capture_pkg::*;

  logic       capture_on;
  logic       capture_last;
  sample_t    glbl_count;
  sample_t    adc_count;
  sample_t    lane_upper;
  sample_t    lane_lower;
  logic       lane_valid;
  logic       fifo_wr_en;
  fifo_word_t fifo_wr_data;

  capture_ctrl #(
    .dds_latency (dds_latency)
  ) u_capture_ctrl (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_enable    (adc_enable),
    .chirp_init    (chirp_init),
    .capture_on    (capture_on),
    .capture_last  (capture_last)
  );

  sample_counters u_sample_counters (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .capture_on    (capture_on),
    .data_valid    (data_valid),
    .glbl_count    (glbl_count),
    .adc_count     (adc_count)
  );

  lane_router u_lane_router (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .route_ctrl    (route_ctrl),
    .data_valid    (data_valid),
    .adc_data      (adc_data),
    .dac_data      (dac_data),
    .glbl_count    (glbl_count),
    .adc_count     (adc_count),
    .lane_upper    (lane_upper),
    .lane_lower    (lane_lower),
    .lane_valid    (lane_valid)
  );

  // only gating point for captured data
  assign fifo_wr_en   = capture_on & lane_valid;
  assign fifo_wr_data = {lane_upper, lane_lower};  // upper lane in the high half

  sample_fifo #(
    .fifo_depth (fifo_depth)
  ) u_sample_fifo (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .wr_en         (fifo_wr_en),
    .wr_data       (fifo_wr_data),
    .wr_last       (capture_last),
    .tdata         (tdata),
    .tvalid        (tvalid),
    .tlast         (tlast),
    .tready        (tready),
    .overflow      (overflow)
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns    = 100,  // full clock period
  parameter int reset_cycles = 3     // rising edges with reset held
) (
  output logic clk_245_76MHz,
  output logic cpu_reset
);

  initial begin
    clk_245_76MHz = 1'b0;
    forever #(period_ns / 2) clk_245_76MHz = ~clk_245_76MHz;
  end

  // sync reset, released on a rising edge like any other input
  initial begin
    cpu_reset = 1'b1;
    repeat (reset_cycles) @(posedge clk_245_76MHz);
    cpu_reset <= 1'b0;
  end

endmodule

// ==== dv/tb_adc_capture.sv ====
`timescale 1ns/1ps

module tb_adc_capture;

  import capture_pkg::*;

  localparam int dds_latency   = 3;   // above default so holds stretch windows
  localparam int fifo_depth    = 16;
  localparam int num_tests     = 6;
  localparam int len_idle      = 20;
  localparam int len_route     = 160;  // 20 route words, 8 cycles each
  localparam int len_count     = 100;
  localparam int len_frame     = 200;
  localparam int len_stall     = 200;
  localparam int len_ovf       = fifo_depth + 8;
  localparam int timeout_limit = len_idle + len_route + len_count + len_frame + len_stall
                                 + len_ovf + 600;  // drains and reset on top

  logic                         clk_245_76MHz;
  logic                         cpu_reset;
  sample_t                      adc_data;
  sample_t                      dac_data;
  logic                         data_valid;
  logic                         chirp_init;
  logic                         adc_enable;
  logic [route_pkg::route_w-1:0] route_ctrl;
  logic                         tready;
  fifo_word_t                   tdata;
  logic                         tvalid;
  logic                         tlast;
  logic                         overflow;

  // model state, advanced at the falling edge ahead of each rising edge
  logic         m_en_r;
  logic         m_on;
  latency_cnt_t m_cnt;
  sample_t      m_glbl;
  sample_t      m_adc_cnt;
  sample_t      m_upper;
  sample_t      m_lower;
  logic         m_lane_valid;
  logic         m_overflow;
  fifo_word_t   exp_data_q [$];  // words still owed by the dut
  logic         exp_last_q [$];

  logic [31:0] rng_state     = 32'd79;
  int          cycle_count   = 0;
  int          error_count   = 0;
  int          words_checked = 0;
  int          test_id       = 0;
  int          win_left      = 0;     // cycles left in enable window or gap
  logic        win_en        = 1'b0;

  tb_clk_gen #(.period_ns(100), .reset_cycles(3)) i_clk_gen (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset)
  );

  adc_capture_top #(.dds_latency(dds_latency), .fifo_depth(fifo_depth)) i_dut (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .adc_data      (adc_data),
    .dac_data      (dac_data),
    .data_valid    (data_valid),
    .chirp_init    (chirp_init),
    .adc_enable    (adc_enable),
    .route_ctrl    (route_ctrl),
    .tdata         (tdata),
    .tvalid        (tvalid),
    .tlast         (tlast),
    .tready        (tready),
    .overflow      (overflow)
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);  // xorshift32
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // lane source per nibble, codes above 3 give the adc sample
  function automatic sample_t model_source(input logic [3:0] code, input sample_t adc,
                                           input sample_t dac, input sample_t acnt,
                                           input sample_t gcnt);
    case (code)
      4'd1:    return dac;
      4'd2:    return acnt;
      4'd3:    return gcnt;
      default: return adc;
    endcase
  endfunction

  function automatic int test_length(input int t);
    case (t)
      1:       return len_idle;
      2:       return len_route;
      3:       return len_count;
      4:       return len_frame;
      5:       return len_stall;
      default: return len_ovf;
    endcase
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1:       return "idle after reset";
      2:       return "routing";
      3:       return "counter sources";
      4:       return "framing and latency hold";
      5:       return "back-pressure";
      default: return "overflow";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one cycle of stimulus, called right after a rising edge
  task automatic drive_cycle(input int t, input int i);
    logic [31:0] r;
    int          step;
    r = next_random();
    adc_data   <= next_random();
    dac_data   <= next_random();
    chirp_init <= 1'b0;
    tready     <= 1'b1;
    adc_enable <= 1'b1;
    data_valid <= r[0];
    route_ctrl <= {2'b00, r[9:8], 2'b00, r[5:4]};  // defined codes
    case (t)
      1: adc_enable <= 1'b0;
      2: begin
        step = i / 8;
        if (step < 16)
          route_ctrl <= {2'b00, step[3:2], 2'b00, step[1:0]};  // all pairs
        else
          route_ctrl <= r[31:24];  // mostly undefined codes
      end
      3: route_ctrl <= ((i / 10) % 2 == 0) ? 8'h23 : 8'h32;
      4: begin
        if (win_left == 0) begin
          win_en   = ~win_en;
          win_left = win_en ? 1 + r[19:16] % 12 : 1 + r[23:20] % 8;
        end
        win_left   = win_left - 1;
        adc_enable <= win_en;
        chirp_init <= (r[14:12] == 3'd0);  // roughly one edge in eight
      end
      5: begin
        tready     <= r[1];
        data_valid <= r[0] && (exp_data_q.size() < fifo_depth - 4);  // two in flight
      end
      default: begin
        tready     <= 1'b0;  // stall through more than fifo_depth writes
        data_valid <= 1'b1;
        route_ctrl <= 8'h30;  // glbl_count high, adc low
      end
    endcase
  endtask

  // close the window, open the stream, wait for the model to go idle
  task automatic drain_fifo();
    @(posedge clk_245_76MHz);
    adc_enable <= 1'b0;
    chirp_init <= 1'b0;
    data_valid <= 1'b0;
    tready     <= 1'b1;
    @(posedge clk_245_76MHz);
    while (m_en_r || m_on || m_cnt != '0 || m_lane_valid || exp_data_q.size() != 0)
      @(posedge clk_245_76MHz);
  endtask

  always @(negedge clk_245_76MHz) begin
    logic    full;
    sample_t nxt_upper;
    sample_t nxt_lower;
    cycle_count = cycle_count + 1;
    if (cpu_reset) begin
      m_en_r       = 1'b0;
      m_on         = 1'b0;
      m_cnt        = '0;
      m_glbl       = '0;
      m_adc_cnt    = '0;
      m_lane_valid = 1'b0;
      m_overflow   = 1'b0;
      exp_data_q.delete();
      exp_last_q.delete();
    end else begin
      check_value("tvalid", tvalid, exp_data_q.size() != 0);
      check_value("overflow", overflow, m_overflow);
      if (test_id == 1) begin
        check_value("tvalid before enable", tvalid, 1'b0);
        check_value("tlast before enable", tlast, 1'b0);
        check_value("overflow before enable", overflow, 1'b0);
      end
      full = (exp_data_q.size() >= fifo_depth);  // occupancy before this edge
      if (tvalid && tready) begin
        if (exp_data_q.size() == 0) begin
          error_count++;
          $display("At %0t the DUT sent a word that the model does not hold", $time);
        end else begin
          check_value("tdata", tdata, exp_data_q.pop_front());
          check_value("tlast", tlast, exp_last_q.pop_front());
          words_checked++;
        end
      end
      if (m_on && m_lane_valid) begin
        if (full)
          m_overflow = 1'b1;  // write lost
        else begin
          exp_data_q.push_back({m_upper, m_lower});
          exp_last_q.push_back(m_on && !m_en_r);
        end
      end
      nxt_upper = model_source(route_ctrl[7:4], adc_data, dac_data, m_adc_cnt, m_glbl);
      nxt_lower = model_source(route_ctrl[3:0], adc_data, dac_data, m_adc_cnt, m_glbl);
      m_upper      = nxt_upper;
      m_lower      = nxt_lower;
      m_lane_valid = data_valid;
      if (m_on && data_valid)
        m_adc_cnt = m_adc_cnt + 1;
      m_glbl = m_glbl + 1;
      if (m_cnt == '0)
        m_on = m_en_r;  // second stage frozen while counting
      if (chirp_init)
        m_cnt = latency_cnt_t'(dds_latency - 1);
      else if (m_cnt != '0)
        m_cnt = m_cnt - 1;
      m_en_r = adc_enable;
    end
  end

  initial begin
    wait (cycle_count >= timeout_limit);
    $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
    $display("Errors found");
    $finish;
  end

  initial begin
    int errors_before;
    adc_data   = '0;
    dac_data   = '0;
    data_valid = 1'b0;
    chirp_init = 1'b0;
    adc_enable = 1'b0;
    route_ctrl = '0;
    tready     = 1'b1;
    wait (cpu_reset === 1'b0);
    for (int t = 1; t <= num_tests; t++) begin
      errors_before = error_count;
      test_id       = t;
      for (int i = 0; i < test_length(t); i++) begin
        @(posedge clk_245_76MHz);
        drive_cycle(t, i);
      end
      drain_fifo();
      if (t == num_tests) begin
        @(negedge clk_245_76MHz);
        check_value("overflow after drain", overflow, 1'b1);  // sticky
      end
      $display("test %0d %s finished with %0d errors", t, test_name(t),
               error_count - errors_before);
    end
    $display("%0d tests, %0d words checked, %0d errors", num_tests, words_checked,
             error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/capture_pkg.sv
verilog/route_pkg.sv
verilog/capture_ctrl.sv
verilog/sample_counters.sv
verilog/lane_router.sv
verilog/sample_fifo.sv
verilog/adc_capture_top.sv
dv/tb_clk_gen.sv
dv/tb_adc_capture.sv
